/* bank_collect.sv */
//////////////////////////////////////////////////////////////////////
// Bank collector
// ORs the bank acks, returns the read word of the addressed bank
//////////////////////////////////////////////////////////////////////
module bank_collect #(
   parameter int DATA_W = 16
) (
   input  logic                            clk,
   input  logic                            rst,
   input  logic [mem_pkg::NUM_BANKS-1:0]   bank_ack,
   input  logic [DATA_W-1:0]               bank_rdata [mem_pkg::NUM_BANKS],
   input  logic [mem_pkg::BANK_SEL_W-1:0]  bank_sel,
   output logic                            mem_ack,
   output logic [DATA_W-1:0]               mem_rdata
);
   import mem_pkg::*;

   // Select frozen while an ack is up
   logic [BANK_SEL_W-1:0] sel_q;

   assign mem_ack   = |bank_ack;
   assign mem_rdata = bank_rdata[sel_q];

   always_ff @(posedge clk) begin
      if (rst) begin
         sel_q <= '0;
      end else if (!mem_ack) begin
         sel_q <= bank_sel;
      end
   end

endmodule

/* bank_dispatch.sv */
//////////////////////////////////////////////////////////////////////
// Bank dispatcher
// Decodes the bank from the word address, routes req to that bank
// Row, write enable and data broadcast to all banks
//////////////////////////////////////////////////////////////////////
module bank_dispatch #(
   parameter int DATA_W = 16
) (
   input  logic                              mem_req,
   input  logic                              mem_we,
   input  logic [mem_pkg::WADDR_W-1:0]       mem_waddr,
   input  logic [DATA_W-1:0]                 mem_wdata,
   output logic [mem_pkg::NUM_BANKS-1:0]     bank_req,
   output logic                              bank_we,
   output logic [mem_pkg::BANK_DEPTH_W-1:0]  bank_row,
   output logic [DATA_W-1:0]                 bank_wdata,
   output logic [mem_pkg::BANK_SEL_W-1:0]    bank_sel
);
   import mem_pkg::*;

   // Low word address bits pick the bank
   assign bank_sel   = mem_waddr[BANK_SEL_W-1:0];
   assign bank_row   = mem_waddr[WADDR_W-1:BANK_SEL_W];
   assign bank_we    = mem_we;
   assign bank_wdata = mem_wdata;

   // Only the selected bank sees req
   always_comb begin
      for (int b = 0; b < NUM_BANKS; b++) begin
         bank_req[b] = mem_req && (bank_sel == BANK_SEL_W'(b));
      end
   end

endmodule

/* cache_array.sv */
//////////////////////////////////////////////////////////////////////
// Direct-mapped cache storage
// Tag, valid and dirty per line, four data words per line
// Combinational tag compare and word read
//////////////////////////////////////////////////////////////////////
module cache_array (
   input  logic                          clk,
   input  logic                          rst,
   input  logic [cache_pkg::INDEX_W-1:0] index,
   input  logic [cache_pkg::TAG_W-1:0]   tag,
   input  logic [cache_pkg::OFFSET_W-2:0] word,
   input  logic [cache_pkg::WORD_W-1:0]  wdata,
   input  logic                          write,
   input  logic                          fill,
   input  logic                          set_dirty,
   output logic                          hit,
   output logic                          dirty,
   output logic [cache_pkg::TAG_W-1:0]   victim_tag,
   output logic [cache_pkg::WORD_W-1:0]  rdata
);
   import cache_pkg::*;

   // Per-line status bits
   logic [2**INDEX_W-1:0] valid_q;
   logic [2**INDEX_W-1:0] dirty_q;

   // Tag and data storage
   logic [TAG_W-1:0]  tag_mem [2**INDEX_W];
   logic [WORD_W-1:0] data_mem [2**INDEX_W][WORDS_PER_BLOCK];

   // Lookup of the addressed line
   assign hit        = valid_q[index] && (tag_mem[index] == tag);
   assign dirty      = dirty_q[index];
   assign victim_tag = tag_mem[index];
   assign rdata      = data_mem[index][word];

   // Valid and dirty bookkeeping
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (write) begin
         // Refill word, line becomes clean and valid
         if (fill) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= 1'b0;
         end
         // Store from the processor
         if (set_dirty) begin
            dirty_q[index] <= 1'b1;
         end
      end
   end

   // Word write, tag load on refill
   always_ff @(posedge clk) begin
      if (write) begin
         data_mem[index][word] <= wdata;
         if (fill) begin
            tag_mem[index] <= tag;
         end
      end
   end

endmodule

/* cache_ctrl.sv */
//////////////////////////////////////////////////////////////////////
// Cache controller FSM
// Hit and miss handling, write-back of dirty victims, block refill
// Four-phase req/ack master towards the banked memory
//////////////////////////////////////////////////////////////////////
module cache_ctrl (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            rd,
   input  logic                            wr,
   input  logic [cache_pkg::ADDR_W-1:0]    addr,
   input  logic [cache_pkg::WORD_W-1:0]    data_in,
   output logic                            done,
   output logic                            stall,
   output logic                            cache_hit,
   output logic                            err,
   output logic [cache_pkg::WORD_W-1:0]    data_out,
   output logic [cache_pkg::INDEX_W-1:0]   arr_index,
   output logic [cache_pkg::TAG_W-1:0]     arr_tag,
   output logic [cache_pkg::OFFSET_W-2:0]  arr_word,
   output logic [cache_pkg::WORD_W-1:0]    arr_wdata,
   output logic                            arr_write,
   output logic                            arr_fill,
   output logic                            arr_set_dirty,
   input  logic                            arr_hit,
   input  logic                            arr_dirty,
   input  logic [cache_pkg::TAG_W-1:0]     arr_victim_tag,
   input  logic [cache_pkg::WORD_W-1:0]    arr_rdata,
   output logic                            mem_req,
   output logic                            mem_we,
   output logic [mem_pkg::WADDR_W-1:0]     mem_waddr,
   output logic [cache_pkg::WORD_W-1:0]    mem_wdata,
   input  logic                            mem_ack,
   input  logic [cache_pkg::WORD_W-1:0]    mem_rdata
);
   import cache_pkg::*;
   import mem_pkg::*;

   ctrl_state_t state, state_nx;

   // Word counter for write-back and refill
   logic [OFFSET_W-2:0] cnt;
   // Request kind and hit result of COMP
   logic op_wr;
   logic hit_q;
   logic last_word;
   logic in_wb;

   assign last_word = (cnt == '1);
   assign in_wb     = (state == WB_REQ) || (state == WB_REL);

   // Processor side
   assign done      = (state == FINISH);
   assign cache_hit = (state == FINISH) && hit_q;
   assign err       = (state == ERR);
   assign stall     = (state == COMP) || in_wb ||
                      (state == FILL_REQ) || (state == FILL_REL);
   assign data_out  = arr_rdata;

   // Line address straight from the held request
   assign arr_index = addr[OFFSET_W +: INDEX_W];
   assign arr_tag   = addr[ADDR_W-1 -: TAG_W];

   // Memory side, victim tag during write-back
   assign mem_req   = (state == WB_REQ) || (state == FILL_REQ);
   assign mem_we    = (state == WB_REQ);
   assign mem_wdata = arr_rdata;
   assign mem_waddr = {(in_wb ? arr_victim_tag : arr_tag), arr_index, cnt};

   always_comb begin
      // Block transfers walk the line, otherwise the requested word
      arr_word      = addr[OFFSET_W-1:1];
      arr_wdata     = data_in;
      arr_write     = 1'b0;
      arr_fill      = 1'b0;
      arr_set_dirty = 1'b0;
      case (state)
         WB_REQ, WB_REL, FILL_REL: begin
            arr_word = cnt;
         end
         FILL_REQ: begin
            arr_word  = cnt;
            arr_wdata = mem_rdata;
            // Install the returned word on ack
            arr_write = mem_ack;
            arr_fill  = mem_ack;
         end
         FINISH: begin
            // Pending store lands here, hit or miss
            arr_write     = op_wr;
            arr_set_dirty = op_wr;
         end
         default: ;
      endcase
   end

   // Next state
   always_comb begin
      state_nx = state;
      case (state)
         IDLE: begin
            if (rd && wr) begin
               state_nx = ERR;
            end else if (rd || wr) begin
               state_nx = COMP;
            end
         end
         COMP: begin
            if (arr_hit) begin
               state_nx = FINISH;
            end else if (arr_dirty) begin
               state_nx = WB_REQ;
            end else begin
               state_nx = FILL_REQ;
            end
         end
         WB_REQ: if (mem_ack) state_nx = WB_REL;
         WB_REL: if (!mem_ack) state_nx = last_word ? FILL_REQ : WB_REQ;
         FILL_REQ: if (mem_ack) state_nx = FILL_REL;
         FILL_REL: if (!mem_ack) state_nx = last_word ? FINISH : FILL_REQ;
         FINISH: state_nx = IDLE;
         default: state_nx = ERR;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= IDLE;
         cnt   <= '0;
         op_wr <= 1'b0;
         hit_q <= 1'b0;
      end else begin
         state <= state_nx;
         if (state == IDLE) begin
            op_wr <= wr;
         end
         if (state == COMP) begin
            hit_q <= arr_hit;
            cnt   <= '0;
         end
         // Advance once the ack has dropped, wraps to 0 after word 3
         if (((state == WB_REL) || (state == FILL_REL)) && !mem_ack) begin
            cnt <= cnt + 1'b1;
         end
      end
   end

endmodule

/* cache_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Cache geometry for the direct-mapped data cache
// Address split into tag, index and word offset
// State encoding of the cache controller FSM
//////////////////////////////////////////////////////////////////////
package cache_pkg;

   // Processor side widths
   localparam int ADDR_W = 16;
   localparam int WORD_W = 16;

   // Addr[2:0] is the byte offset, bit 0 unused
   localparam int OFFSET_W = 3;
   // Addr[7:3] selects one of 32 lines
   localparam int INDEX_W = 5;
   // Addr[15:8]
   localparam int TAG_W = 8;

   localparam int WORDS_PER_BLOCK = 4;

   // Controller states
   typedef enum logic [2:0] {
      IDLE,
      COMP,
      WB_REQ,
      WB_REL,
      FILL_REQ,
      FILL_REL,
      FINISH,
      ERR
   } ctrl_state_t;

endpackage

/* mem_bank.sv */
//////////////////////////////////////////////////////////////////////
// One memory bank
// Word array with a fixed-latency four-phase responder
//////////////////////////////////////////////////////////////////////
module mem_bank #(
   parameter int DATA_W = 16
) (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              req,
   input  logic                              we,
   input  logic [mem_pkg::BANK_DEPTH_W-1:0]  row,
   input  logic [DATA_W-1:0]                 wdata,
   output logic                              ack,
   output logic [DATA_W-1:0]                 rdata
);
   import mem_pkg::*;

   logic [DATA_W-1:0] mem [2**BANK_DEPTH_W];

   // Latency counter, busy between seen req and ack
   logic                                  busy;
   logic [$clog2(BANK_LATENCY+1)-1:0]     lat_cnt;
   logic                                  fire;

   assign fire = busy && (lat_cnt == '0);

   // Memory starts out all zero
   initial begin
      for (int i = 0; i < 2**BANK_DEPTH_W; i++) begin
         mem[i] = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         busy    <= 1'b0;
         lat_cnt <= '0;
         ack     <= 1'b0;
      end else begin
         if (fire) begin
            busy <= 1'b0;
            ack  <= 1'b1;
         end else if (busy) begin
            lat_cnt <= lat_cnt - 1'b1;
         end else if (req && !ack) begin
            // New request seen
            busy    <= 1'b1;
            lat_cnt <= $bits(lat_cnt)'(BANK_LATENCY - 1);
         end
         // Release phase, ack follows req down
         if (ack && !req) begin
            ack <= 1'b0;
         end
      end
   end

   // Read data held until the next access
   always_ff @(posedge clk) begin
      if (fire && !we) begin
         rdata <= mem[row];
      end
   end

   always @(posedge clk) begin
      if (fire && we) begin
         mem[row] <= wdata;
      end
   end

endmodule

/* mem_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Geometry and timing of the four-bank word memory
// Bank select, row width and response latency
//////////////////////////////////////////////////////////////////////
package mem_pkg;

   // One word of a block per bank
   localparam int NUM_BANKS = 4;
   localparam int BANK_SEL_W = 2;

   // Word address, Addr[15:1] of the processor
   localparam int WADDR_W = 15;

   // Row inside a bank, word address bits 14..2
   localparam int BANK_DEPTH_W = 13;

   // Cycles from a seen req to a raised ack
   localparam int BANK_LATENCY = 2;

endpackage

/* mem_system.sv */
//////////////////////////////////////////////////////////////////////
// Data cache with banked backing memory, top level
// Controller, cache array, dispatcher, four banks and collector
//////////////////////////////////////////////////////////////////////
module mem_system (
   input  logic                          clk,
   input  logic                          rst,
   input  logic [cache_pkg::ADDR_W-1:0]  addr,
   input  logic [cache_pkg::WORD_W-1:0]  data_in,
   input  logic                          rd,
   input  logic                          wr,
   output logic [cache_pkg::WORD_W-1:0]  data_out,
   output logic                          done,
   output logic                          stall,
   output logic                          cache_hit,
   output logic                          err
);
   import cache_pkg::*;
   import mem_pkg::*;

   // Controller to array
   logic [INDEX_W-1:0]  arr_index;
   logic [TAG_W-1:0]    arr_tag;
   logic [OFFSET_W-2:0] arr_word;
   logic [WORD_W-1:0]   arr_wdata;
   logic                arr_write;
   logic                arr_fill;
   logic                arr_set_dirty;
   logic                arr_hit;
   logic                arr_dirty;
   logic [TAG_W-1:0]    arr_victim_tag;
   logic [WORD_W-1:0]   arr_rdata;

   // Controller to memory
   logic                mem_req;
   logic                mem_we;
   logic [WADDR_W-1:0]  mem_waddr;
   logic [WORD_W-1:0]   mem_wdata;
   logic                mem_ack;
   logic [WORD_W-1:0]   mem_rdata;

   // Bank network
   logic [NUM_BANKS-1:0]    bank_req;
   logic [NUM_BANKS-1:0]    bank_ack;
   logic                    bank_we;
   logic [BANK_DEPTH_W-1:0] bank_row;
   logic [WORD_W-1:0]       bank_wdata;
   logic [WORD_W-1:0]       bank_rdata [NUM_BANKS];
   logic [BANK_SEL_W-1:0]   bank_sel;

   cache_ctrl u_ctrl (
      .clk            (clk),
      .rst            (rst),
      .rd             (rd),
      .wr             (wr),
      .addr           (addr),
      .data_in        (data_in),
      .done           (done),
      .stall          (stall),
      .cache_hit      (cache_hit),
      .err            (err),
      .data_out       (data_out),
      .arr_index      (arr_index),
      .arr_tag        (arr_tag),
      .arr_word       (arr_word),
      .arr_wdata      (arr_wdata),
      .arr_write      (arr_write),
      .arr_fill       (arr_fill),
      .arr_set_dirty  (arr_set_dirty),
      .arr_hit        (arr_hit),
      .arr_dirty      (arr_dirty),
      .arr_victim_tag (arr_victim_tag),
      .arr_rdata      (arr_rdata),
      .mem_req        (mem_req),
      .mem_we         (mem_we),
      .mem_waddr      (mem_waddr),
      .mem_wdata      (mem_wdata),
      .mem_ack        (mem_ack),
      .mem_rdata      (mem_rdata)
   );

   cache_array u_array (
      .clk        (clk),
      .rst        (rst),
      .index      (arr_index),
      .tag        (arr_tag),
      .word       (arr_word),
      .wdata      (arr_wdata),
      .write      (arr_write),
      .fill       (arr_fill),
      .set_dirty  (arr_set_dirty),
      .hit        (arr_hit),
      .dirty      (arr_dirty),
      .victim_tag (arr_victim_tag),
      .rdata      (arr_rdata)
   );

   bank_dispatch #(.DATA_W(WORD_W)) u_dispatch (
      .mem_req    (mem_req),
      .mem_we     (mem_we),
      .mem_waddr  (mem_waddr),
      .mem_wdata  (mem_wdata),
      .bank_req   (bank_req),
      .bank_we    (bank_we),
      .bank_row   (bank_row),
      .bank_wdata (bank_wdata),
      .bank_sel   (bank_sel)
   );

   // One bank per word of a block
   for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
      mem_bank #(.DATA_W(WORD_W)) u_bank (
         .clk   (clk),
         .rst   (rst),
         .req   (bank_req[g]),
         .we    (bank_we),
         .row   (bank_row),
         .wdata (bank_wdata),
         .ack   (bank_ack[g]),
         .rdata (bank_rdata[g])
      );
   end

   bank_collect #(.DATA_W(WORD_W)) u_collect (
      .clk        (clk),
      .rst        (rst),
      .bank_ack   (bank_ack),
      .bank_rdata (bank_rdata),
      .bank_sel   (bank_sel),
      .mem_ack    (mem_ack),
      .mem_rdata  (mem_rdata)
   );

endmodule

/* mem_system_checker.sv */
//////////////////////////////////////////////////////////////////////
// Concurrent assertions on the processor and memory handshakes
// Bound into the cache top level
//////////////////////////////////////////////////////////////////////
module mem_system_checker (
   input logic                          clk,
   input logic                          rst,
   input logic                          done,
   input logic                          stall,
   input logic                          mem_req,
   input logic                          mem_ack,
   input logic [mem_pkg::NUM_BANKS-1:0] bank_ack
);

   // Number of failed assertions
   int fail_cnt = 0;

   // done is a single-cycle pulse
   done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
      else begin
         fail_cnt++;
         $error("done stayed high for more than one cycle");
      end

   // Four-phase master keeps req up until ack
   req_hold: assert property (@(posedge clk) disable iff (rst)
      mem_req && !mem_ack |=> mem_req)
      else begin
         fail_cnt++;
         $error("mem_req dropped before mem_ack rose");
      end

   // One request in flight, so one bank answers
   one_ack: assert property (@(posedge clk) disable iff (rst) $onehot0(bank_ack))
      else begin
         fail_cnt++;
         $error("more than one bank_ack high");
      end

   no_stall_done: assert property (@(posedge clk) disable iff (rst) !(stall && done))
      else begin
         fail_cnt++;
         $error("stall and done high in the same cycle");
      end

endmodule

bind mem_system mem_system_checker u_checker (
   .clk      (clk),
   .rst      (rst),
   .done     (done),
   .stall    (stall),
   .mem_req  (mem_req),
   .mem_ack  (mem_ack),
   .bank_ack (bank_ack)
);

/* mem_system_stim.txt */
# op addr wdata hit : R load, W store, X rd and wr together
# addr and wdata in hex, hit is the expected cache_hit (0 or 1)
R 0010 0000 0
R 0012 0000 1
W 0014 a5a5 1
R 0014 0000 1
W 032a beef 0
W 0128 1234 0
R 012a 0000 1
R 0128 0000 1
R 032a 0000 0
R 0128 0000 0
W 032c 5555 0
R 032a 0000 1
R 032c 0000 1
W 0440 1111 0
W 0442 2222 1
W 0444 3333 1
W 0446 4444 1
R 0540 0000 0
R 0440 0000 0
R 0442 0000 1
R 0446 0000 1
X 0000 0000 0

/* run.sh */
#!/bin/sh
# Compile and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_mem_system -f vlog.f
out=$(./obj_dir/Vtb_mem_system +verilator+error+limit+100) || true
echo "$out"
if echo "$out" | grep -qxF '** PASS **'; then
   exit 0
fi
exit 1

/* tb_mem_system.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the data cache with banked memory
// Stimulus reader, memory image and tag/valid reference model
// Load data, hit flag, stall and hit latency checks, timeout
//////////////////////////////////////////////////////////////////////
module tb_mem_system;
   import cache_pkg::*;

   localparam int CYCLES_PER_OP = 40;
   localparam int RESET_CYCLES  = 5;

   logic              clk = 1'b0;
   logic              rst;
   logic [ADDR_W-1:0] addr;
   logic [WORD_W-1:0] data_in;
   logic              rd;
   logic              wr;
   logic [WORD_W-1:0] data_out;
   logic              done;
   logic              stall;
   logic              cache_hit;
   logic              err;

   // Operations from the stimulus file
   byte               op_q[$];
   logic [15:0]       addr_q[$];
   logic [15:0]       data_q[$];
   logic [15:0]       stim_hit_q[$];

   // Reference model, latest value of every word plus line tags
   logic [WORD_W-1:0] image [2**15];
   logic [31:0]       valid_m;
   logic [TAG_W-1:0]  tag_m [32];

   int mismatches = 0;
   int other_errors = 0;
   int cycles = 0;
   int cycle_limit = 0;

   mem_system dut (
      .clk       (clk),
      .rst       (rst),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   always #50 clk = ~clk;

   // Run length bound, set once the stimulus is known
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("** FAIL **");
         $finish;
      end
   end

   task automatic compare_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
      if (expected !== actual) begin
         mismatches++;
         $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic read_stim();
      int          fd;
      int          c;
      int          n;
      byte         ch;
      logic [15:0] a;
      logic [15:0] d;
      logic [15:0] h;
      fd = $fopen("mem_system_stim.txt", "r");
      if (fd == 0) begin
         other_errors++;
         $display("Could not open the stimulus file mem_system_stim.txt");
         return;
      end
      c = $fgetc(fd);
      while (c != -1) begin
         ch = 8'(c);
         if (ch == "#") begin
            // Comment runs to the end of the line
            while (c != -1 && ch != "\n") begin
               c = $fgetc(fd);
               ch = 8'(c);
            end
         end else if (ch == "R" || ch == "W" || ch == "X") begin
            n = $fscanf(fd, "%h %h %h", a, d, h);
            if (n != 3) begin
               other_errors++;
               $display("Stimulus line for operation %c is incomplete", ch);
            end
            op_q.push_back(ch);
            addr_q.push_back(a);
            data_q.push_back(d);
            stim_hit_q.push_back(h);
         end
         c = $fgetc(fd);
      end
      $fclose(fd);
   endtask

   // One load or store, waits for done
   task automatic run_access(input int i);
      string             name;
      logic [14:0]       waddr;
      logic [INDEX_W-1:0] idx;
      logic [TAG_W-1:0]  t;
      logic              exp_hit;
      int                lat;
      name    = $sformatf("op %0d %c %h", i, op_q[i], addr_q[i]);
      waddr   = addr_q[i][15:1];
      idx     = addr_q[i][7:3];
      t       = addr_q[i][15:8];
      exp_hit = valid_m[idx] && (tag_m[idx] == t);
      compare_value({name, " stim hit column"}, 32'(exp_hit), 32'(stim_hit_q[i]));
      addr    = addr_q[i];
      data_in = data_q[i];
      rd      = (op_q[i] == "R");
      wr      = (op_q[i] == "W");
      lat     = 1;
      @(negedge clk);
      while (!done) begin
         compare_value({name, " stall"}, 1, 32'(stall));
         @(negedge clk);
         lat++;
      end
      compare_value({name, " cache_hit"}, 32'(exp_hit), 32'(cache_hit));
      if (exp_hit) begin
         compare_value({name, " hit latency"}, 2, lat);
      end
      if (op_q[i] == "R") begin
         compare_value({name, " data_out"}, 32'(image[waddr]), 32'(data_out));
      end else begin
         image[waddr] = data_q[i];
      end
      valid_m[idx] = 1'b1;
      tag_m[idx]   = t;
      rd = 1'b0;
      wr = 1'b0;
      // Idle cycle between requests
      @(negedge clk);
   endtask

   // rd and wr together, err must rise and stick
   task automatic run_conflict(input int i);
      int n;
      addr    = addr_q[i];
      data_in = data_q[i];
      rd      = 1'b1;
      wr      = 1'b1;
      n       = 0;
      @(negedge clk);
      while (!err && n < 4) begin
         compare_value("conflict done", 0, 32'(done));
         @(negedge clk);
         n++;
      end
      if (!err) begin
         other_errors++;
         $display("err did not rise after rd and wr were raised together");
      end
      rd = 1'b0;
      wr = 1'b0;
      repeat (8) begin
         @(negedge clk);
         compare_value("conflict err", 1, 32'(err));
         compare_value("conflict done", 0, 32'(done));
      end
   endtask

   initial begin
      rst     = 1'b1;
      rd      = 1'b0;
      wr      = 1'b0;
      addr    = '0;
      data_in = '0;
      valid_m = '0;
      for (int i = 0; i < 2**15; i++) begin
         image[i] = '0;
      end
      read_stim();
      cycle_limit = (op_q.size() + 1) * CYCLES_PER_OP + RESET_CYCLES;
      repeat (RESET_CYCLES) @(negedge clk);
      compare_value("reset done", 0, 32'(done));
      compare_value("reset stall", 0, 32'(stall));
      compare_value("reset cache_hit", 0, 32'(cache_hit));
      compare_value("reset err", 0, 32'(err));
      rst = 1'b0;
      @(negedge clk);
      for (int i = 0; i < op_q.size(); i++) begin
         if (op_q[i] == "X") begin
            run_conflict(i);
         end else begin
            run_access(i);
         end
      end
      compare_value("assertion failures", 0, dut.u_checker.fail_cnt);
      $display("Ran %0d operations: %0d mismatches, %0d other errors",
               op_q.size(), mismatches, other_errors);
      if (mismatches == 0 && other_errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

/* vlog.f */
cache_pkg.sv
mem_pkg.sv
cache_array.sv
cache_ctrl.sv
bank_dispatch.sv
mem_bank.sv
bank_collect.sv
mem_system.sv
mem_system_checker.sv
tb_mem_system.sv
